// File: eeprom_store.f
hdl/eeprom_pkg.sv
hdl/eeprom_ram.sv
hdl/rtc_stamp_writer.sv
hdl/backup_transfer.sv
hdl/eeprom_arbiter.sv
hdl/eeprom_store_top.sv
sim/eeprom_checker.sv
sim/tb_eeprom_store.sv

// File: hdl/backup_transfer.sv
`timescale 1ns/1ps
`default_nettype none

module backup_transfer (
  input  wire                                   clk_sys_32,
  input  wire                                   reset,
  input  wire [eeprom_pkg::sector_index_w-1:0]  sd_lba,
  input  wire [eeprom_pkg::sector_offset_w-1:0] sd_buff_addr,
  input  wire [eeprom_pkg::ee_data_w-1:0]       sd_buff_dout,
  input  wire                                   sd_buff_wr,
  input  wire                                   sd_ack,
  input  wire                                   cart_download,
  input  wire                                   img_mounted,
  input  wire                                   img_readonly,
  input  wire                                   console_we,
  input  wire [eeprom_pkg::ee_data_w-1:0]       backup_rdata,
  output logic                                  backup_we,
  output logic [eeprom_pkg::ee_addr_w-1:0]      backup_address,
  output logic [eeprom_pkg::ee_data_w-1:0]      backup_wdata,
  output logic                                  backup_read_active,
  output logic [eeprom_pkg::ee_data_w-1:0]      sd_buff_din,
  output logic                                  save_enable,
  output logic                                  load_request,
  output logic                                  save_pending
);

  logic download_q;
  logic ack_q;
  logic download_rise;
  logic download_fall;
  logic ack_rise;

  ////////////////////////////////////////////////////////////////////////////
  // sector buffer path

  // sixteen 512 byte blocks cover the whole image
  assign backup_address     = {sd_lba, sd_buff_addr};
  assign backup_we          = sd_buff_wr & sd_ack;    // load from sd
  assign backup_wdata       = sd_buff_dout;
  assign backup_read_active = sd_ack & ~sd_buff_wr;   // save to sd
  assign sd_buff_din        = backup_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // save tracking flags

  assign download_rise = cart_download & ~download_q;
  assign download_fall = ~cart_download & download_q;
  assign ack_rise      = sd_ack & ~ack_q;

  always_ff @(posedge clk_sys_32) begin
    if (reset) begin
      download_q   <= 1'b0;
      ack_q        <= 1'b0;
      save_enable  <= 1'b0;
      load_request <= 1'b0;
      save_pending <= 1'b0;
    end else begin
      download_q <= cart_download;
      ack_q      <= sd_ack;

      if (download_rise) save_enable <= 1'b0;   // new cart, forget the old image
      if (cart_download && img_mounted && !img_readonly) save_enable <= 1'b1;

      // pull the save in once the rom is loaded
      if (download_fall && save_enable) begin
        load_request <= 1'b1;
      end else if (ack_rise) begin
        load_request <= 1'b0;
      end

      if (console_we && save_enable) begin
        save_pending <= 1'b1;
      end else if (ack_rise) begin
        save_pending <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/eeprom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_arbiter (
  input  wire                              clk_sys_32,
  input  wire                              reset,
  input  wire                              rtc_we,
  input  wire [eeprom_pkg::ee_addr_w-1:0]  rtc_address,
  input  wire [eeprom_pkg::ee_data_w-1:0]  rtc_wdata,
  input  wire                              backup_we,
  input  wire [eeprom_pkg::ee_addr_w-1:0]  backup_address,
  input  wire [eeprom_pkg::ee_data_w-1:0]  backup_wdata,
  input  wire                              backup_read_active,
  input  wire                              console_we,
  input  wire [eeprom_pkg::ee_addr_w-1:0]  console_address,
  input  wire [eeprom_pkg::ee_data_w-1:0]  console_wdata,
  output logic                             mem_we,
  output logic [eeprom_pkg::ee_addr_w-1:0] mem_address,
  output logic [eeprom_pkg::ee_data_w-1:0] mem_wdata,
  input  wire [eeprom_pkg::ee_data_w-1:0]  mem_rdata,
  output logic [eeprom_pkg::ee_data_w-1:0] backup_rdata,
  output logic [eeprom_pkg::ee_data_w-1:0] console_rdata
);
  import eeprom_pkg::*;

  mem_owner_t           owner_next;
  mem_owner_t           owner_q;     // who drove the port last cycle
  logic [ee_data_w-1:0] backup_hold;
  logic [ee_data_w-1:0] console_hold;

  ////////////////////////////////////////////////////////////////////////////
  // port selection, writes first

  always_comb begin
    owner_next  = owner_console;   // idle port reads for the console
    mem_we      = 1'b0;
    mem_address = console_address;
    mem_wdata   = console_wdata;
    if (rtc_we) begin
      owner_next  = owner_rtc;
      mem_we      = 1'b1;
      mem_address = rtc_address;
      mem_wdata   = rtc_wdata;
    end else if (backup_we) begin
      owner_next  = owner_backup;
      mem_we      = 1'b1;
      mem_address = backup_address;
      mem_wdata   = backup_wdata;
    end else if (console_we) begin
      mem_we = 1'b1;
    end else if (backup_read_active) begin
      owner_next  = owner_backup;   // sd save streaming out
      mem_address = backup_address;
    end
  end

  always_ff @(posedge clk_sys_32) begin
    if (reset) begin
      owner_q <= owner_none;
    end else begin
      owner_q <= owner_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data return

  always_ff @(posedge clk_sys_32) begin
    backup_hold  <= backup_rdata;
    console_hold <= console_rdata;
  end

  assign backup_rdata  = (owner_q == owner_backup)  ? mem_rdata : backup_hold;
  assign console_rdata = (owner_q == owner_console) ? mem_rdata : console_hold;

endmodule

`default_nettype wire

// File: hdl/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // memory and bus geometry

  localparam int ee_addr_w  = 13;
  localparam int ee_data_w  = 8;
  localparam int ee_depth   = 8192;
  localparam int bus_addr_w = 24;

  localparam int sector_index_w  = 4;   // low bits of the sd block number
  localparam int sector_offset_w = 9;   // byte within a 512 byte sector

  ////////////////////////////////////////////////////////////////////////////
  // boot stamp layout

  localparam logic [bus_addr_w-1:0] stamp_trigger_addr = 24'h0000AB;

  localparam int header_count = 11;

  // signature at the bottom, fixed config bytes just below the clock fields
  localparam logic [ee_addr_w-1:0] header_addr_table [header_count] = '{
    13'h0000, 13'h0001, 13'h0002, 13'h0003,
    13'h1FF2, 13'h1FF3, 13'h1FF4, 13'h1FF5,
    13'h1FF6, 13'h1FF7, 13'h1FF8
  };

  localparam logic [ee_data_w-1:0] header_data_table [header_count] = '{
    8'h47, 8'h42, 8'h4D, 8'h4E,   // "GBMN"
    8'h01, 8'h03, 8'h01, 8'h1F,
    8'h00, 8'h00, 8'h00
  };

  localparam logic [ee_addr_w-1:0] rtc_field_base    = 13'h1FF9; // year first
  localparam logic [ee_addr_w-1:0] rtc_checksum_addr = 13'h1FFF;

  ////////////////////////////////////////////////////////////////////////////
  // state and owner encodings

  typedef enum logic [1:0] {
    stamp_idle     = 2'd0,
    stamp_header   = 2'd1,
    stamp_clock    = 2'd2,
    stamp_checksum = 2'd3
  } stamp_state_t;

  typedef enum logic [1:0] {
    owner_none    = 2'd0,
    owner_rtc     = 2'd1,
    owner_backup  = 2'd2,
    owner_console = 2'd3
  } mem_owner_t;

endpackage

`default_nettype wire

// File: hdl/eeprom_ram.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ram (
  input  wire                             clk_sys_32,
  input  wire                             we,
  input  wire [eeprom_pkg::ee_addr_w-1:0] address,
  input  wire [eeprom_pkg::ee_data_w-1:0] wdata,
  output logic [eeprom_pkg::ee_data_w-1:0] rdata
);
  import eeprom_pkg::*;

  logic [ee_data_w-1:0] mem [ee_depth];

  // write and read share one address per cycle
  always_ff @(posedge clk_sys_32) begin
    if (we) begin
      mem[address] <= wdata;
    end
    rdata <= mem[address];   // old byte on a same-cycle write
  end

endmodule

`default_nettype wire

// File: hdl/eeprom_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_store_top (
  input  wire                                   clk_sys_32,
  input  wire                                   reset,

  // console side
  input  wire [eeprom_pkg::bus_addr_w-1:0]      bus_address,
  input  wire [47:0]                            rtc_timestamp,
  input  wire                                   console_we,
  input  wire [eeprom_pkg::ee_addr_w-1:0]       console_address,
  input  wire [eeprom_pkg::ee_data_w-1:0]       console_wdata,
  output wire [eeprom_pkg::ee_data_w-1:0]       console_rdata,
  output wire                                   validate_rtc,

  // sd sector buffer
  input  wire [eeprom_pkg::sector_index_w-1:0]  sd_lba,
  input  wire [eeprom_pkg::sector_offset_w-1:0] sd_buff_addr,
  input  wire [eeprom_pkg::ee_data_w-1:0]       sd_buff_dout,
  input  wire                                   sd_buff_wr,
  input  wire                                   sd_ack,
  output wire [eeprom_pkg::ee_data_w-1:0]       sd_buff_din,

  // image and download status
  input  wire                                   cart_download,
  input  wire                                   img_mounted,
  input  wire                                   img_readonly,
  output wire                                   save_enable,
  output wire                                   load_request,
  output wire                                   save_pending
);
  import eeprom_pkg::*;

  wire                 rtc_we;
  wire [ee_addr_w-1:0] rtc_address;
  wire [ee_data_w-1:0] rtc_wdata;

  wire                 backup_we;
  wire [ee_addr_w-1:0] backup_address;
  wire [ee_data_w-1:0] backup_wdata;
  wire                 backup_read_active;
  wire [ee_data_w-1:0] backup_rdata;

  wire                 mem_we;
  wire [ee_addr_w-1:0] mem_address;
  wire [ee_data_w-1:0] mem_wdata;
  wire [ee_data_w-1:0] mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // peers

  rtc_stamp_writer rtc_stamp (
    .clk_sys_32    (clk_sys_32),
    .reset         (reset),
    .bus_address   (bus_address),
    .rtc_timestamp (rtc_timestamp),
    .rtc_we        (rtc_we),
    .rtc_address   (rtc_address),
    .rtc_wdata     (rtc_wdata),
    .validate_rtc  (validate_rtc)
  );

  backup_transfer backup (
    .clk_sys_32         (clk_sys_32),
    .reset              (reset),
    .sd_lba             (sd_lba),
    .sd_buff_addr       (sd_buff_addr),
    .sd_buff_dout       (sd_buff_dout),
    .sd_buff_wr         (sd_buff_wr),
    .sd_ack             (sd_ack),
    .cart_download      (cart_download),
    .img_mounted        (img_mounted),
    .img_readonly       (img_readonly),
    .console_we         (console_we),   // marks the image dirty
    .backup_rdata       (backup_rdata),
    .backup_we          (backup_we),
    .backup_address     (backup_address),
    .backup_wdata       (backup_wdata),
    .backup_read_active (backup_read_active),
    .sd_buff_din        (sd_buff_din),
    .save_enable        (save_enable),
    .load_request       (load_request),
    .save_pending       (save_pending)
  );

  ////////////////////////////////////////////////////////////////////////////
  // shared memory port

  eeprom_arbiter arbiter (
    .clk_sys_32         (clk_sys_32),
    .reset              (reset),
    .rtc_we             (rtc_we),
    .rtc_address        (rtc_address),
    .rtc_wdata          (rtc_wdata),
    .backup_we          (backup_we),
    .backup_address     (backup_address),
    .backup_wdata       (backup_wdata),
    .backup_read_active (backup_read_active),
    .console_we         (console_we),
    .console_address    (console_address),
    .console_wdata      (console_wdata),
    .mem_we             (mem_we),
    .mem_address        (mem_address),
    .mem_wdata          (mem_wdata),
    .mem_rdata          (mem_rdata),
    .backup_rdata       (backup_rdata),
    .console_rdata      (console_rdata)
  );

  eeprom_ram ram (
    .clk_sys_32 (clk_sys_32),
    .we         (mem_we),
    .address    (mem_address),
    .wdata      (mem_wdata),
    .rdata      (mem_rdata)
  );

endmodule

`default_nettype wire

// File: hdl/rtc_stamp_writer.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_stamp_writer (
  input  wire                              clk_sys_32,
  input  wire                              reset,
  input  wire [eeprom_pkg::bus_addr_w-1:0] bus_address,
  input  wire [47:0]                       rtc_timestamp,  // bcd, year at the top
  output logic                             rtc_we,
  output logic [eeprom_pkg::ee_addr_w-1:0] rtc_address,
  output logic [eeprom_pkg::ee_data_w-1:0] rtc_wdata,
  output logic                             validate_rtc
);
  import eeprom_pkg::*;

  stamp_state_t         state;
  logic [3:0]           stage;        // index within header or clock fields
  logic                 armed;
  logic                 trigger;
  logic [ee_data_w-1:0] checksum_acc;
  logic [2:0]           field_sel;
  logic [ee_data_w-1:0] field_bcd;
  logic [ee_data_w-1:0] field_bin;

  function automatic logic [7:0] bcd2bin(input logic [7:0] bcd);
    bcd2bin = {4'd0, bcd[7:4]} * 8'd10 + {4'd0, bcd[3:0]};
  endfunction

  // stage 0 is year, the top byte of the timestamp
  assign field_sel = 3'd5 - stage[2:0];
  assign field_bcd = rtc_timestamp[field_sel*8 +: 8];
  assign field_bin = bcd2bin(field_bcd);

  assign trigger = (state == stamp_idle) && armed && (bus_address == stamp_trigger_addr);

  ////////////////////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk_sys_32) begin
    if (reset) begin
      state <= stamp_idle;
      stage <= '0;
      armed <= 1'b1;
    end else begin
      case (state)
        stamp_idle: begin
          if (bus_address != stamp_trigger_addr) armed <= 1'b1;  // console moved on
          if (trigger) begin
            state <= stamp_header;
            stage <= '0;
            armed <= 1'b0;
          end
        end
        stamp_header: begin
          if (stage == 4'(header_count - 1)) begin
            state <= stamp_clock;
            stage <= '0;
          end else begin
            stage <= stage + 4'd1;
          end
        end
        stamp_clock: begin
          if (stage == 4'd5) begin   // second field done
            state <= stamp_checksum;
            stage <= '0;
          end else begin
            stage <= stage + 4'd1;
          end
        end
        stamp_checksum: state <= stamp_idle;
        default: state <= stamp_idle;
      endcase
    end
  end

  // running sum of the binary fields, ready by the checksum cycle
  always_ff @(posedge clk_sys_32) begin
    if (trigger) begin
      checksum_acc <= '0;
    end else if (state == stamp_clock) begin
      checksum_acc <= checksum_acc + field_bin;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write port, one byte per cycle outside idle

  always_comb begin
    rtc_we      = 1'b0;
    rtc_address = '0;
    rtc_wdata   = '0;
    case (state)
      stamp_header: begin
        rtc_we      = 1'b1;
        rtc_address = header_addr_table[stage];
        rtc_wdata   = header_data_table[stage];
      end
      stamp_clock: begin
        rtc_we      = 1'b1;
        rtc_address = rtc_field_base + ee_addr_w'(stage);
        rtc_wdata   = field_bin;
      end
      stamp_checksum: begin
        rtc_we      = 1'b1;
        rtc_address = rtc_checksum_addr;
        rtc_wdata   = checksum_acc;
      end
      default: ;
    endcase
  end

  assign validate_rtc = (state != stamp_idle);   // 18 cycles per stamp

endmodule

`default_nettype wire

// File: sim/eeprom_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_checker (
  input  wire                                   clk_sys_32,
  input  wire                                   reset,
  input  wire [eeprom_pkg::bus_addr_w-1:0]      bus_address,
  input  wire [47:0]                            rtc_timestamp,
  input  wire                                   console_we,
  input  wire [eeprom_pkg::ee_addr_w-1:0]       console_address,
  input  wire [eeprom_pkg::ee_data_w-1:0]       console_wdata,
  input  wire [eeprom_pkg::ee_data_w-1:0]       console_rdata,
  input  wire                                   validate_rtc,
  input  wire [eeprom_pkg::sector_index_w-1:0]  sd_lba,
  input  wire [eeprom_pkg::sector_offset_w-1:0] sd_buff_addr,
  input  wire [eeprom_pkg::ee_data_w-1:0]       sd_buff_dout,
  input  wire                                   sd_buff_wr,
  input  wire                                   sd_ack,
  input  wire [eeprom_pkg::ee_data_w-1:0]       sd_buff_din,
  input  wire                                   cart_download,
  input  wire                                   img_mounted,
  input  wire                                   img_readonly,
  input  wire                                   save_enable,
  input  wire                                   load_request,
  input  wire                                   save_pending,
  input  wire                                   expect_en,
  input  wire [eeprom_pkg::ee_data_w-1:0]       expect_data,
  output int                                    data_errors,
  output int                                    flag_errors
);
  import eeprom_pkg::*;

  logic [7:0]  image [8192];            // reference copy of the eeprom
  logic [7:0]  exp_con, exp_sd, exp_tab;
  logic        con_pend, sd_pend, tab_pend;
  logic        armed, idle, any_write, dl_q, ack_q;
  logic        ref_enable, ref_load, ref_pending;
  logic [12:0] wr_addr;
  logic [7:0]  wr_data;
  int          stamp_idx;               // -1 while no stamp runs

  function automatic logic [7:0] to_binary(input logic [7:0] bcd);
    return (bcd >> 4) * 8'd10 + (bcd & 8'h0f);
  endfunction

  // step 0..10 header, 11..16 clock fields, 17 checksum
  task automatic stamp_entry(input int idx, output logic [12:0] a, output logic [7:0] d);
    logic [7:0] sum;
    sum = 8'd0;
    a = (idx < 4) ? idx : 13'h1FEE + idx;
    case (idx)
      0: d = 8'h47;
      1: d = 8'h42;
      2: d = 8'h4D;
      3: d = 8'h4E;
      4, 6: d = 8'h01;
      5: d = 8'h03;
      7: d = 8'h1F;
      default: d = 8'h00;
    endcase
    if (idx >= 11 && idx < 17) d = to_binary(rtc_timestamp[8*(16-idx) +: 8]);
    if (idx == 17) begin
      for (int k = 0; k < 6; k++) sum = sum + to_binary(rtc_timestamp[8*k +: 8]);
      d = sum;
    end
  endtask

  task automatic report_data(input string what, input logic [7:0] got, input logic [7:0] want);
    data_errors++;
    $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, want);
  endtask

  initial begin
    data_errors = 0;
    flag_errors = 0;
  end

  always @(posedge clk_sys_32) begin
    if (reset) begin
      stamp_idx = -1;
      armed = 1'b1;
      {dl_q, ack_q, con_pend, sd_pend, tab_pend} = '0;
      {ref_enable, ref_load, ref_pending} = '0;
    end else begin
      ////////////////////////////////////////////////////////////////////////
      // results of last cycle's reads
      if (con_pend && console_rdata !== exp_con) report_data("console", console_rdata, exp_con);
      if (sd_pend && sd_buff_din !== exp_sd) report_data("sd save", sd_buff_din, exp_sd);
      if (tab_pend && console_rdata !== exp_tab) report_data("table", console_rdata, exp_tab);
      if (validate_rtc !== (stamp_idx >= 0)) begin
        flag_errors++;
        $display("CHECK FAILED at %0t: validate_rtc is %b", $time, validate_rtc);
      end
      if ({save_enable, load_request, save_pending} !== {ref_enable, ref_load, ref_pending}) begin
        flag_errors++;
        $display("CHECK FAILED at %0t: flags %b, expected %b", $time,
                 {save_enable, load_request, save_pending}, {ref_enable, ref_load, ref_pending});
      end

      ////////////////////////////////////////////////////////////////////////
      // this cycle's port use, reads see the old bytes
      idle      = (stamp_idx < 0);
      any_write = !idle || (sd_buff_wr && sd_ack) || console_we;
      exp_con   = image[console_address];
      exp_sd    = image[{sd_lba, sd_buff_addr}];
      con_pend  = !any_write && !sd_ack && (^exp_con !== 1'bx);   // skip unwritten bytes
      sd_pend   = !any_write && sd_ack && (^exp_sd !== 1'bx);
      tab_pend  = expect_en;
      exp_tab   = expect_data;

      if (!idle) begin   // stamp beats load beats console
        stamp_entry(stamp_idx, wr_addr, wr_data);
        image[wr_addr] = wr_data;
        stamp_idx = (stamp_idx == 17) ? -1 : stamp_idx + 1;
      end else if (sd_buff_wr && sd_ack) begin
        image[{sd_lba, sd_buff_addr}] = sd_buff_dout;
      end else if (console_we) begin
        image[console_address] = console_wdata;
      end

      if (idle && armed && bus_address == stamp_trigger_addr) begin
        stamp_idx = 0;
        armed = 1'b0;
      end else if (idle && bus_address != stamp_trigger_addr) begin
        armed = 1'b1;
      end

      // flags, old save_enable gates the set terms
      if (!cart_download && dl_q && ref_enable) ref_load = 1'b1;
      else if (sd_ack && !ack_q) ref_load = 1'b0;
      if (console_we && ref_enable) ref_pending = 1'b1;
      else if (sd_ack && !ack_q) ref_pending = 1'b0;
      if (cart_download && !dl_q) ref_enable = 1'b0;
      if (cart_download && img_mounted && !img_readonly) ref_enable = 1'b1;
      dl_q  = cart_download;
      ack_q = sd_ack;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_eeprom_store.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_store;
  import eeprom_pkg::*;

  typedef enum logic [2:0] {
    op_con_wr, op_con_rd, op_sd_load, op_sd_save, op_stamp, op_download
  } op_t;

  // exp only counts when chk is set
  typedef struct packed {
    op_t         op;
    logic [12:0] addr;
    logic [7:0]  data;
    logic        chk;
    logic [7:0]  exp;
  } row_t;

  logic                      clk_sys_32, reset;
  logic [bus_addr_w-1:0]     bus_address;
  logic [47:0]               rtc_timestamp;
  logic                      console_we, sd_buff_wr, sd_ack, cart_download;
  logic                      img_mounted, img_readonly, expect_en, table_ready;
  logic [ee_addr_w-1:0]      console_address;
  logic [ee_data_w-1:0]      console_wdata, sd_buff_dout, expect_data;
  logic [sector_index_w-1:0] sd_lba;
  logic [sector_offset_w-1:0] sd_buff_addr;
  wire  [ee_data_w-1:0]      console_rdata, sd_buff_din;
  wire                       validate_rtc, save_enable, load_request, save_pending;
  int                        data_errors, flag_errors;
  integer                    seed;
  row_t                      rows [$];

  eeprom_store_top UUT (.*);
  eeprom_checker scoreboard (.*);

  initial begin
    clk_sys_32 = 1'b0;
    forever #20 clk_sys_32 = ~clk_sys_32;
  end

  task automatic add_row(input op_t op, input logic [12:0] addr, input logic [7:0] data,
                         input logic chk, input logic [7:0] exp);
    rows.push_back({op, addr, data, chk, exp});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one row of stimulus on the falling edges
  task automatic apply_row(input row_t r);
    @(negedge clk_sys_32);
    case (r.op)
      op_con_wr: {console_we, console_address, console_wdata} = {1'b1, r.addr, r.data};
      op_con_rd: {console_address, expect_en, expect_data} = {r.addr, r.chk, r.exp};
      op_sd_load: begin
        {sd_ack, sd_buff_wr, sd_lba, sd_buff_addr} = {2'b11, r.addr};
        sd_buff_dout = $random(seed);
      end
      op_sd_save: {sd_ack, sd_lba, sd_buff_addr} = {1'b1, r.addr};
      op_stamp: bus_address = stamp_trigger_addr;
      op_download: {img_readonly, cart_download} = r.data[1:0];   // bit 1 read-only image
      default: ;
    endcase
    @(negedge clk_sys_32);
    {console_we, expect_en, sd_ack, sd_buff_wr} = '0;
    if (r.op == op_stamp) begin
      // console hits the first header write
      {console_we, console_address, console_wdata} = {1'b1, r.addr, r.data};
      @(negedge clk_sys_32);
      console_we = 1'b0;
      wait (validate_rtc == 1'b0);
      repeat (3) @(negedge clk_sys_32);   // address still held in idle
      bus_address = '0;
    end
  endtask

  initial begin
    seed = 32'h67d9a9da;
    reset = 1'b1;
    table_ready = 1'b0;
    bus_address = '0;
    rtc_timestamp = 48'h24_12_31_23_59_58;   // bcd year..second
    {console_we, sd_buff_wr, sd_ack, cart_download, img_readonly, expect_en} = '0;
    img_mounted = 1'b1;
    {console_address, console_wdata, sd_buff_dout, expect_data, sd_lba, sd_buff_addr} = '0;

    add_row(op_download, 13'h0000, 8'h01, 1'b0, 8'h00);   // save_enable
    add_row(op_download, 13'h0000, 8'h00, 1'b0, 8'h00);   // load_request
    add_row(op_con_wr,   13'h0100, 8'h5A, 1'b0, 8'h00);   // save_pending
    add_row(op_sd_load,  13'h0080, 8'h00, 1'b0, 8'h00);   // ack rise clears both
    add_row(op_sd_load,  13'h07A5, 8'h00, 1'b0, 8'h00);
    add_row(op_sd_load,  13'h18FF, 8'h00, 1'b0, 8'h00);
    add_row(op_con_rd,   13'h0080, 8'h00, 1'b0, 8'h00);
    add_row(op_con_rd,   13'h07A5, 8'h00, 1'b0, 8'h00);
    add_row(op_con_rd,   13'h18FF, 8'h00, 1'b0, 8'h00);
    add_row(op_con_rd,   13'h0100, 8'h00, 1'b1, 8'h5A);
    add_row(op_stamp,    13'h0000, 8'hEE, 1'b0, 8'h00);
    add_row(op_con_rd,   13'h0000, 8'h00, 1'b1, 8'h47);   // rtc write won
    add_row(op_con_rd,   13'h0003, 8'h00, 1'b1, 8'h4E);
    add_row(op_con_rd,   13'h1FF2, 8'h00, 1'b1, 8'h01);
    add_row(op_con_rd,   13'h1FF5, 8'h00, 1'b1, 8'h1F);
    add_row(op_con_rd,   13'h1FF8, 8'h00, 1'b1, 8'h00);
    add_row(op_con_rd,   13'h1FF9, 8'h00, 1'b1, 8'h18);   // year 24
    add_row(op_con_rd,   13'h1FFA, 8'h00, 1'b1, 8'h0C);
    add_row(op_con_rd,   13'h1FFB, 8'h00, 1'b1, 8'h1F);
    add_row(op_con_rd,   13'h1FFC, 8'h00, 1'b1, 8'h17);
    add_row(op_con_rd,   13'h1FFD, 8'h00, 1'b1, 8'h3B);
    add_row(op_con_rd,   13'h1FFE, 8'h00, 1'b1, 8'h3A);
    add_row(op_con_rd,   13'h1FFF, 8'h00, 1'b1, 8'hCF);   // 207 mod 256
    add_row(op_sd_save,  13'h0080, 8'h00, 1'b0, 8'h00);
    add_row(op_sd_save,  13'h07A5, 8'h00, 1'b0, 8'h00);
    add_row(op_sd_save,  13'h18FF, 8'h00, 1'b0, 8'h00);
    add_row(op_sd_save,  13'h1FFF, 8'h00, 1'b0, 8'h00);
    add_row(op_download, 13'h0000, 8'h03, 1'b0, 8'h00);   // read-only image drops save_enable
    add_row(op_download, 13'h0000, 8'h02, 1'b0, 8'h00);   // no load_request on this fall
    add_row(op_con_wr,   13'h0100, 8'hA5, 1'b0, 8'h00);   // no save_pending now
    table_ready = 1'b1;

    repeat (2) @(posedge clk_sys_32);
    @(negedge clk_sys_32);
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) apply_row(rows[i]);
    repeat (3) @(negedge clk_sys_32);

    $display("errors: %0d data, %0d flag", data_errors, flag_errors);
    if (data_errors + flag_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready);
    repeat (rows.size() * 30 + 100) @(posedge clk_sys_32);
    $display("timeout: the stimulus table did not finish in %0d cycles", rows.size() * 30 + 100);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
